//--- src/procPkg.sv
`default_nettype none
//******************************
// Processor definitions
// Opcodes, ALU operations and the
// instruction word in both formats
//******************************

package procPkg;

	// Opcodes, anything not listed is illegal
	typedef enum logic [3:0] {
		opNop  = 4'd0,
		opAdd  = 4'd1,
		opSub  = 4'd2,
		opAnd  = 4'd3,
		opXor  = 4'd4,
		opAddi = 4'd5,
		opLd   = 4'd6,
		opSt   = 4'd7,
		opBeqz = 4'd8,
		opHalt = 4'd15
	} opcodeT;

	typedef enum logic [1:0] {
		aluAdd = 2'd0,
		aluSub = 2'd1,
		aluAnd = 2'd2,
		aluXor = 2'd3
	} aluOpT;

	// One 16-bit word, read as R-format or I-format
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [2:0] rd;
			logic [2:0] rs;
			logic [2:0] rt;
			logic [2:0] unused;
		} rForm;
		struct packed {
			logic [3:0]        opcode;
			logic [2:0]        rd;
			logic [2:0]        rs;
			logic signed [5:0] imm;
		} iForm;
	} instrWord;

	// Word inserted when the fetched instruction is flushed
	localparam logic [15:0] NOP_WORD = 16'h0000;

endpackage

`default_nettype wire

//--- src/stageBus.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Pipeline stage bus
// Control and data of one
// instruction between two stages
//******************************

interface stageBus;
	logic            valid;
	procPkg::aluOpT  aluOp;
	logic            useImm;
	logic            memRead;
	logic            memWrite;
	logic            regWrite;
	logic            isHalt;
	logic [2:0]      destReg;
	logic [15:0]     opA;
	logic [15:0]     opB;
	logic [15:0]     imm;
	logic [15:0]     result;

	// Upstream stage registers every field
	modport src (output valid, aluOp, useImm, memRead, memWrite, regWrite, isHalt,
		destReg, opA, opB, imm, result);

	modport dst (input valid, aluOp, useImm, memRead, memWrite, regWrite, isHalt,
		destReg, opA, opB, imm, result);
endinterface

`default_nettype wire

//--- src/fetch.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Fetch stage
// PC register and the
// fetch/decode register
//******************************

module fetch (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        halting,
	input  logic        branchTaken,
	input  logic [15:0] branchTarget,
	input  logic [15:0] imemData,
	output logic [15:0] imemAddr,
	output logic [15:0] fdInstr,
	output logic [15:0] fdPc
);

	logic [15:0] pc;

	// Word addressed, read comes back in the same cycle
	assign imemAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			fdInstr <= procPkg::NOP_WORD;
			fdPc <= '0;
		end else if (!stall && !halting) begin
			fdPc <= pc;
			if (branchTaken) begin
				// Drop the word fetched behind the branch
				pc <= branchTarget;
				fdInstr <= procPkg::NOP_WORD;
			end else begin
				pc <= pc + 16'd1;
				fdInstr <= imemData;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/decode.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Decode stage
// Register file, control decode,
// branch resolution, illegal ops
//******************************

module decode (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] fdInstr,
	input  logic [15:0] fdPc,
	input  logic        stall,
	input  logic        wbEn,
	input  logic [2:0]  wbReg,
	input  logic [15:0] wbData,
	output logic [2:0]  srcA,
	output logic [2:0]  srcB,
	output logic        usesA,
	output logic        usesB,
	output logic        branchTaken,
	output logic [15:0] branchTarget,
	output logic        halting,
	output logic        err,
	stageBus.src        dx
);

	procPkg::instrWord iw;
	procPkg::opcodeT   op;
	procPkg::aluOpT    aluOp;
	logic [15:0] regs [8];
	logic [15:0] readA;
	logic [15:0] readB;
	logic [15:0] immExt;
	logic        legal;
	logic        isBranch;
	logic        useImm;
	logic        memRead;
	logic        memWrite;
	logic        regWrite;
	logic        isHalt;
	logic        issue;
	logic        haltSeen;

	assign iw = fdInstr;
	assign op = procPkg::opcodeT'(iw.rForm.opcode);
	assign immExt = {{10{iw.iForm.imm[5]}}, iw.iForm.imm};
	assign srcA = iw.rForm.rs;

	// Writeback in the same cycle is seen here
	assign readA = (wbEn && wbReg == srcA) ? wbData : regs[srcA];
	assign readB = (wbEn && wbReg == srcB) ? wbData : regs[srcB];

	always_comb begin
		legal = 1'b1;
		aluOp = procPkg::aluAdd;
		useImm = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		isHalt = 1'b0;
		isBranch = 1'b0;
		usesA = 1'b0;
		usesB = 1'b0;
		// I-format reads rd for store data and branch test
		srcB = iw.iForm.rd;
		case (op)
			procPkg::opNop: ;
			procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor: begin
				regWrite = 1'b1;
				usesA = 1'b1;
				usesB = 1'b1;
				srcB = iw.rForm.rt;
				case (op)
					procPkg::opSub: aluOp = procPkg::aluSub;
					procPkg::opAnd: aluOp = procPkg::aluAnd;
					procPkg::opXor: aluOp = procPkg::aluXor;
					default: aluOp = procPkg::aluAdd;
				endcase
			end
			procPkg::opAddi: begin
				useImm = 1'b1;
				regWrite = 1'b1;
				usesA = 1'b1;
			end
			procPkg::opLd: begin
				useImm = 1'b1;
				memRead = 1'b1;
				regWrite = 1'b1;
				usesA = 1'b1;
			end
			procPkg::opSt: begin
				useImm = 1'b1;
				memWrite = 1'b1;
				usesA = 1'b1;
				usesB = 1'b1;
			end
			procPkg::opBeqz: begin
				isBranch = 1'b1;
				usesB = 1'b1;
			end
			procPkg::opHalt: isHalt = 1'b1;
			default: legal = 1'b0;
		endcase
	end

	// Nothing leaves decode during a stall or after HALT
	assign issue = !stall && !haltSeen;
	assign halting = haltSeen || (issue && isHalt);
	assign branchTaken = issue && isBranch && readB == 16'h0000;
	assign branchTarget = fdPc + 16'd1 + immExt;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn) begin
			regs[wbReg] <= wbData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			haltSeen <= 1'b0;
			err <= 1'b0;
			dx.valid <= 1'b0;
		end else begin
			if (issue && isHalt)
				haltSeen <= 1'b1;
			// Sticky until reset
			if (issue && !legal)
				err <= 1'b1;
			dx.valid <= issue && legal;
		end
	end

	always_ff @(posedge clk) begin
		dx.aluOp <= aluOp;
		dx.useImm <= useImm;
		dx.memRead <= memRead;
		dx.memWrite <= memWrite;
		dx.regWrite <= regWrite;
		dx.isHalt <= isHalt;
		dx.destReg <= iw.iForm.rd;
		dx.opA <= readA;
		dx.opB <= readB;
		dx.imm <= immExt;
		// Filled in by execute
		dx.result <= '0;
	end

endmodule

`default_nettype wire

//--- src/hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Hazard detection
// Stalls decode on RAW against
// execute and memory
//******************************

module hazardDetect (
	input  logic [2:0] srcA,
	input  logic [2:0] srcB,
	input  logic       usesA,
	input  logic       usesB,
	output logic       stall,
	stageBus.dst       dx,
	stageBus.dst       em
);

	logic hitX;
	logic hitM;

	assign hitX = dx.valid && dx.regWrite &&
		((usesA && dx.destReg == srcA) || (usesB && dx.destReg == srcB));

	assign hitM = em.valid && em.regWrite &&
		((usesA && em.destReg == srcA) || (usesB && em.destReg == srcB));

	// Writeback needs no check, the register file bypasses it
	assign stall = hitX || hitM;

endmodule

`default_nettype wire

//--- src/execute.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Execute stage
// ALU and execute/memory register
//******************************

module execute (
	input  logic clk,
	input  logic rst,
	stageBus.dst dx,
	stageBus.src em
);

	logic [15:0] operandB;
	logic [15:0] aluOut;

	assign operandB = dx.useImm ? dx.imm : dx.opB;

	// Loads and stores get their address here
	always_comb begin
		case (dx.aluOp)
			procPkg::aluSub: aluOut = dx.opA - operandB;
			procPkg::aluAnd: aluOut = dx.opA & operandB;
			procPkg::aluXor: aluOut = dx.opA ^ operandB;
			default: aluOut = dx.opA + operandB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			em.valid <= 1'b0;
		else
			em.valid <= dx.valid;
	end

	always_ff @(posedge clk) begin
		em.aluOp <= dx.aluOp;
		em.useImm <= dx.useImm;
		em.memRead <= dx.memRead;
		em.memWrite <= dx.memWrite;
		em.regWrite <= dx.regWrite;
		em.isHalt <= dx.isHalt;
		em.destReg <= dx.destReg;
		em.opA <= dx.opA;
		// Store data rides along in opB
		em.opB <= dx.opB;
		em.imm <= dx.imm;
		em.result <= aluOut;
	end

endmodule

`default_nettype wire

//--- src/memory.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Memory stage
// Data memory and the
// memory/writeback register
//******************************

module memory #(
	parameter int memWords = 64
) (
	input  logic clk,
	input  logic rst,
	stageBus.dst em,
	stageBus.src mw
);

	localparam int addrBits = $clog2(memWords);

	logic [15:0]         mem [memWords];
	logic [addrBits-1:0] addr;

	// Low bits of the ALU result pick the word
	assign addr = em.result[addrBits-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < memWords; i++) begin
				mem[i] <= '0;
			end
		end else if (em.valid && em.memWrite) begin
			mem[addr] <= em.opB;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			mw.valid <= 1'b0;
		else
			mw.valid <= em.valid;
	end

	always_ff @(posedge clk) begin
		mw.aluOp <= em.aluOp;
		mw.useImm <= em.useImm;
		mw.memRead <= em.memRead;
		mw.memWrite <= em.memWrite;
		mw.regWrite <= em.regWrite;
		mw.isHalt <= em.isHalt;
		mw.destReg <= em.destReg;
		mw.opA <= em.opA;
		mw.opB <= em.opB;
		mw.imm <= em.imm;
		mw.result <= em.memRead ? mem[addr] : em.result;
	end

endmodule

`default_nettype wire

//--- src/proc.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Five-stage 16-bit processor
// Connects the stages, drives
// writeback and holds halt state
//******************************

module proc #(
	parameter int memWords = 64
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] imemData,
	output logic [15:0] imemAddr,
	output logic        wbEn,
	output logic [2:0]  wbReg,
	output logic [15:0] wbData,
	output logic        halted,
	output logic        err
);

	logic [15:0] fdInstr;
	logic [15:0] fdPc;
	logic [15:0] branchTarget;
	logic        branchTaken;
	logic        stall;
	logic        halting;
	logic [2:0]  srcA;
	logic [2:0]  srcB;
	logic        usesA;
	logic        usesB;

	stageBus dxBus ();
	stageBus emBus ();
	stageBus mwBus ();

	fetch fetch0 (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.halting(halting),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.imemData(imemData),
		.imemAddr(imemAddr),
		.fdInstr(fdInstr),
		.fdPc(fdPc)
	);

	decode decode0 (
		.clk(clk),
		.rst(rst),
		.fdInstr(fdInstr),
		.fdPc(fdPc),
		.stall(stall),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.srcA(srcA),
		.srcB(srcB),
		.usesA(usesA),
		.usesB(usesB),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.halting(halting),
		.err(err),
		.dx(dxBus.src)
	);

	hazardDetect hazard0 (
		.srcA(srcA),
		.srcB(srcB),
		.usesA(usesA),
		.usesB(usesB),
		.stall(stall),
		.dx(dxBus.dst),
		.em(emBus.dst)
	);

	execute execute0 (
		.clk(clk),
		.rst(rst),
		.dx(dxBus.dst),
		.em(emBus.src)
	);

	memory #(
		.memWords(memWords)
	) memory0 (
		.clk(clk),
		.rst(rst),
		.em(emBus.dst),
		.mw(mwBus.src)
	);

	// Writeback
	assign wbEn = mwBus.valid && mwBus.regWrite;
	assign wbReg = mwBus.destReg;
	assign wbData = mwBus.result;

	always_ff @(posedge clk) begin
		if (rst)
			halted <= 1'b0;
		else if (mwBus.valid && mwBus.isHalt)
			halted <= 1'b1;
	end

endmodule

`default_nettype wire

//--- test/tbClock.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Testbench clock
// Free-running, 8 ns period
//******************************

module tbClock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

endmodule

`default_nettype wire

//--- test/procChecker.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Pipeline control assertions
// Halt state, writeback and PC hold
//******************************

module procChecker (
	input logic        clk,
	input logic        rst,
	input logic        halted,
	input logic        wbEn,
	input logic        stall,
	input logic [15:0] imemAddr
);

	// Only reset clears halted
	haltSticky: assert property (@(posedge clk) (halted && !rst) |=> halted)
		else $error("halted fell without reset");

	noWbWhenHalted: assert property (@(posedge clk) (halted && !rst) |-> !wbEn)
		else $error("writeback while halted");

	// Stall freezes the PC
	pcHeldOnStall: assert property (@(posedge clk) (stall && !rst) |=> $stable(imemAddr))
		else $error("imemAddr moved during a stall");

endmodule

`default_nettype wire

//--- test/procMonitor.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Instruction-set model and
// writeback, halt and err checks
//******************************

module procMonitor #(
	parameter int progWords = 64,
	parameter int memWords = 64
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        checkEnd,
	input  logic [15:0] prog [progWords],
	input  logic        wbEn,
	input  logic [2:0]  wbReg,
	input  logic [15:0] wbData,
	input  logic        halted,
	input  logic        err,
	output int          errors,
	output int          writebacks
);

	logic [2:0]  expReg [$];
	logic [15:0] expData [$];
	logic        expErr;
	logic        errSeen;
	logic        haltSeen;
	int          wbIdx;
	int          errCount = 0;
	int          wbTotal = 0;

	assign errors = errCount;
	assign writebacks = wbTotal;

	// Runs the program sequentially and records every register write
	task automatic runModel();
		logic [15:0] regs [8];
		logic [15:0] mem [memWords];
		procPkg::instrWord w;
		logic [15:0] pc;
		logic [15:0] immExt;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] val;
		int addr;
		int steps;
		logic done;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		for (int i = 0; i < memWords; i++)
			mem[i] = '0;
		expReg.delete();
		expData.delete();
		expErr = 1'b0;
		pc = '0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 400) begin
			w = (pc < progWords) ? prog[pc] : 16'h0000;
			immExt = {{10{w.iForm.imm[5]}}, w.iForm.imm};
			a = regs[w.rForm.rs];
			b = regs[w.rForm.rt];
			addr = int'((a + immExt) & 16'(memWords - 1));
			pc = pc + 16'd1;
			steps++;
			case (w.rForm.opcode)
				procPkg::opNop: ;
				procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor,
				procPkg::opAddi, procPkg::opLd: begin
					case (w.rForm.opcode)
						procPkg::opAdd: val = a + b;
						procPkg::opSub: val = a - b;
						procPkg::opAnd: val = a & b;
						procPkg::opXor: val = a ^ b;
						procPkg::opAddi: val = a + immExt;
						default: val = mem[addr];
					endcase
					regs[w.rForm.rd] = val;
					expReg.push_back(w.rForm.rd);
					expData.push_back(val);
				end
				procPkg::opSt: mem[addr] = regs[w.iForm.rd];
				procPkg::opBeqz: begin
					if (regs[w.iForm.rd] == 16'h0000)
						pc = pc + immExt;
				end
				procPkg::opHalt: done = 1'b1;
				// Illegal opcodes act as NOP
				default: expErr = 1'b1;
			endcase
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			runModel();
			wbIdx = 0;
			errSeen = 1'b0;
			haltSeen = 1'b0;
		end else begin
			if (wbEn) begin
				wbTotal++;
				if (wbIdx >= expReg.size()) begin
					$display("Writeback with no matching instruction in the model");
					errCount++;
				end else begin
					if (wbReg !== expReg[wbIdx]) begin
						$display("Fail wbReg expected %h actual %h", expReg[wbIdx], wbReg);
						errCount++;
					end
					if (wbData !== expData[wbIdx]) begin
						$display("Fail wbData expected %h actual %h", expData[wbIdx], wbData);
						errCount++;
					end
				end
				wbIdx++;
			end
			// HALT retires only after every earlier writeback
			if (halted === 1'b1 && !haltSeen) begin
				haltSeen = 1'b1;
				if (wbIdx != expReg.size()) begin
					$display("halted rose after %0d of %0d writebacks",
						wbIdx, expReg.size());
					errCount++;
				end
			end
			if (err === 1'b1 && !errSeen) begin
				errSeen = 1'b1;
				if (!expErr) begin
					$display("err rose in a program without an illegal opcode");
					errCount++;
				end
			end else if (errSeen && err !== 1'b1) begin
				$display("err fell before reset");
				errCount++;
			end
			if (checkEnd) begin
				if (wbIdx != expReg.size()) begin
					$display("Writeback count %0d differs from the model's %0d",
						wbIdx, expReg.size());
					errCount++;
				end
				if (err !== expErr) begin
					$display("Fail err expected %h actual %h", expErr, err);
					errCount++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- test/procTb.sv
`timescale 1ns/1ps
`default_nettype none
//******************************
// Processor testbench
// Random programs, reset, timeout
//******************************

module procTb;

	localparam int progWords = 64;
	localparam int memWords = 64;
	localparam int numTests = 8;
	localparam int progLen = 41;
	// Six cycles per instruction plus reset and end check
	localparam int cycleLimit = numTests * (6 * progLen + 8 + 4);

	logic        clk;
	logic        rst;
	logic        checkEnd;
	logic [15:0] imemData;
	logic [15:0] imemAddr;
	logic        wbEn;
	logic [2:0]  wbReg;
	logic [15:0] wbData;
	logic        halted;
	logic        err;
	logic [15:0] prog [progWords];
	int          errors;
	int          writebacks;
	int          cycles = 0;
	integer      seed;

	tbClock clock0 (.clk(clk));

	proc #(.memWords(memWords)) i_dut (
		.clk(clk),
		.rst(rst),
		.imemData(imemData),
		.imemAddr(imemAddr),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted),
		.err(err)
	);

	procMonitor #(.progWords(progWords), .memWords(memWords)) monitor0 (
		.clk(clk),
		.rst(rst),
		.checkEnd(checkEnd),
		.prog(prog),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted),
		.err(err),
		.errors(errors),
		.writebacks(writebacks)
	);

	bind proc procChecker chk0 (.*);

	// Combinational instruction memory
	assign imemData = (imemAddr < progWords) ? prog[imemAddr] : 16'h0000;

	function automatic int pick(int range);
		return int'($unsigned($random(seed)) % range);
	endfunction

	// Forty legal instructions ending in HALT behind an optional illegal word
	task automatic makeProgram(input logic withIllegal);
		procPkg::instrWord w;
		int base;
		int maxImm;
		int kind;
		int slot;
		for (int i = 0; i < progWords; i++)
			prog[i] = 16'h0000;
		base = withIllegal ? 1 : 0;
		if (withIllegal)
			prog[0] = {4'(9 + pick(6)), 12'(pick(4096))};
		for (int pc = base; pc < base + 39; pc++) begin
			kind = pick(9);
			w = '0;
			// Few registers give dense dependency chains
			w.iForm.rd = 3'(pick(4));
			w.iForm.rs = 3'(pick(4));
			case (kind)
				0: w.rForm.opcode = procPkg::opNop;
				1, 2, 3, 4: begin
					w.rForm.opcode = 4'(kind);
					w.rForm.rt = 3'(pick(4));
				end
				5: begin
					w.iForm.opcode = procPkg::opAddi;
					w.iForm.imm = 6'(pick(64));
				end
				6, 7: begin
					w.iForm.opcode = (kind == 6) ? procPkg::opLd : procPkg::opSt;
					w.iForm.imm = 6'(pick(4));
				end
				default: begin
					w.iForm.opcode = procPkg::opBeqz;
					maxImm = base + 38 - pc;
					if (maxImm > 31)
						maxImm = 31;
					w.iForm.imm = 6'(pick(maxImm + 1));
				end
			endcase
			prog[pc] = w;
		end
		// Opening store and load of one word with nonzero data
		slot = pick(4);
		prog[base] = {procPkg::opAddi, 3'd1, 3'd0, 6'(1 + pick(31))};
		prog[base + 1] = {procPkg::opSt, 3'd1, 3'd2, 6'(slot)};
		prog[base + 2] = {procPkg::opLd, 3'd3, 3'd2, 6'(slot)};
		prog[base + 39] = {procPkg::opHalt, 12'h000};
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Timeout after %0d cycles, the processor never halted", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		seed = 94;
		rst = 1'b1;
		checkEnd = 1'b0;
		for (int t = 0; t < numTests; t++) begin
			makeProgram(t == numTests - 1);
			rst = 1'b1;
			repeat (8) @(negedge clk);
			rst = 1'b0;
			while (halted !== 1'b1)
				@(negedge clk);
			checkEnd = 1'b1;
			@(negedge clk);
			checkEnd = 1'b0;
			@(negedge clk);
		end
		$display("Programs %0d, writebacks %0d, errors %0d", numTests, writebacks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- proc.f
src/procPkg.sv
src/stageBus.sv
src/fetch.sv
src/decode.sv
src/hazardDetect.sv
src/execute.sv
src/memory.sv
src/proc.sv
test/tbClock.sv
test/procChecker.sv
test/procMonitor.sv
test/procTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module procTb -f proc.f -o procSim || exit 1
out=$(./obj_dir/procSim)
echo "$out"
echo "$out" | grep -q "Testbench passed" && exit 0 || exit 1
